//--- list.f
rtl/tilePkg.sv
rtl/ramWriteIf.sv
rtl/dualPortRam.sv
rtl/depthTest.sv
rtl/tileClear.sv
rtl/tileReadback.sv
rtl/tileBuffer.sv
bench/tileBufferTb.sv

//--- run.sh
#!/bin/sh
# builds the tile buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tileBufferTb \
    -f list.f \
    -o tileBufferSim

./obj_dir/tileBufferSim

//--- bench/tileBufferTb.sv
`timescale 1ns/10ps
`default_nettype none

// random fragment traffic into the tile buffer is checked against a colour
// and depth model of the whole tile through full readback scans
module tileBufferTb;

    import tilePkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int SEED          = 28076;
    localparam int NUM_PIXELS    = 1 << TILE_ADDR_BITS;
    localparam int MASK_BITS     = COLOR_BITS / CHANNEL_BITS;
    localparam int RANDOM_FRAGS  = 400;
    localparam int HOT_FRAGS     = 400;
    localparam int SPECIAL_FRAGS = 64; // fragments in each group of the fixed-function test
    // four clears and five scans, plus every fragment and the pipeline drains
    localparam int STIM_CYCLES   = 9 * (NUM_PIXELS + 8) + RANDOM_FRAGS + HOT_FRAGS
                                   + 4 * SPECIAL_FRAGS + 64;
    localparam int WATCHDOG_NS   = (STIM_CYCLES + 4 * NUM_PIXELS) * CLK_PERIOD * 3 / 2;

    // a few addresses that get hammered back to back
    localparam logic [TILE_ADDR_BITS-1:0] HOT_ADDR [4] = '{8'd3, 8'd4, 8'd130, 8'd255};

    logic                      clk;
    logic                      reset;
    logic                      fragValid;
    logic [TILE_ADDR_BITS-1:0] fragAddr;
    depthT                     fragDepth;
    colorT                     fragColor;
    logic [MASK_BITS-1:0]      colorMask;
    depthFuncT                 depthFunc;
    logic                      depthWriteEnable;
    logic                      clearStart;
    colorT                     clearColor;
    depthT                     clearDepth;
    logic                      clearBusy;
    logic                      readStart;
    logic                      readBusy;
    logic                      pixelValid;
    logic [TILE_ADDR_BITS-1:0] pixelIndex;
    colorT                     pixelData;

    colorT       modelColor [NUM_PIXELS]; // what the colour buffer should hold
    depthT       modelDepth [NUM_PIXELS];
    logic [31:0] rndA;
    logic [31:0] rndB;

    tileBuffer #(.TILE_ADDR_BITS(TILE_ADDR_BITS)) dut_i (
        .clk              (clk),
        .reset            (reset),
        .fragValid        (fragValid),
        .fragAddr         (fragAddr),
        .fragDepth        (fragDepth),
        .fragColor        (fragColor),
        .colorMask        (colorMask),
        .depthFunc        (depthFunc),
        .depthWriteEnable (depthWriteEnable),
        .clearStart       (clearStart),
        .clearColor       (clearColor),
        .clearDepth       (clearDepth),
        .clearBusy        (clearBusy),
        .readStart        (readStart),
        .readBusy         (readBusy),
        .pixelValid       (pixelValid),
        .pixelIndex       (pixelIndex),
        .pixelData        (pixelData)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic reportFailure(input string message);
        $display("%s", message);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // depth rule that tests the incoming depth against the stored one
    function automatic logic depthPasses(input depthFuncT func, input depthT fragZ,
                                         input depthT storedZ);
        logic below;
        logic same;
        below = fragZ < storedZ;
        same  = fragZ == storedZ;
        case (func)
            depthNever:        return 1'b0;
            depthLess:         return below;
            depthLessEqual:    return below || same;
            depthEqual:        return same;
            depthGreater:      return !below && !same;
            depthGreaterEqual: return !below;
            depthNotEqual:     return !same;
            default:           return 1'b1;
        endcase
    endfunction

    // sends one fragment per call and updates the model in arrival order
    task automatic sendFragment(input logic [TILE_ADDR_BITS-1:0] addr, input depthT z,
                                input colorT color, input logic [MASK_BITS-1:0] mask,
                                input depthFuncT func, input logic zWrite);
        colorT merged;
        @(posedge clk);
        fragValid        <= 1'b1;
        fragAddr         <= addr;
        fragDepth        <= z;
        fragColor        <= color;
        colorMask        <= mask;
        depthFunc        <= func;
        depthWriteEnable <= zWrite;
        if (depthPasses(func, z, modelDepth[addr]))
        begin
            merged = modelColor[addr];
            for (int ch = 0; ch < MASK_BITS; ch++)
            begin
                if (mask[ch]) // bit n of the mask owns nibble n
                begin
                    merged[ch*CHANNEL_BITS +: CHANNEL_BITS] =
                        color[ch*CHANNEL_BITS +: CHANNEL_BITS];
                end
            end
            modelColor[addr] = merged;
            if (zWrite)
            begin
                modelDepth[addr] = z;
            end
        end
    endtask

    // the last fragment reaches the RAMs two edges after it was sampled
    task automatic drainPipeline();
        @(posedge clk);
        fragValid <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic clearTile(input colorT color, input depthT z);
        int busyCycles;
        @(posedge clk);
        clearStart <= 1'b1;
        clearColor <= color;
        clearDepth <= z;
        @(posedge clk);
        clearStart <= 1'b0; // the sweep started on this edge
        busyCycles = 0;
        @(negedge clk);
        while (clearBusy && (busyCycles <= NUM_PIXELS))
        begin
            assert (!pixelValid)
            else reportFailure($sformatf("Fail pixelValid during clear: expected 0, got %h",
                                         pixelValid));
            busyCycles++;
            @(negedge clk);
        end
        assert (busyCycles == NUM_PIXELS)
        else reportFailure($sformatf("Fail clearBusy cycles: expected %h, got %h",
                                     NUM_PIXELS, busyCycles));
        for (int a = 0; a < NUM_PIXELS; a++)
        begin
            modelColor[a] = color;
            modelDepth[a] = z;
        end
    endtask

    // scans the whole colour buffer and compares each pixel with the model
    task automatic readTile();
        logic [TILE_ADDR_BITS-1:0] expIndex;
        @(posedge clk);
        readStart <= 1'b1;
        @(posedge clk);
        readStart <= 1'b0;
        @(negedge clk);
        assert (readBusy)
        else reportFailure($sformatf("Fail readBusy after readStart: expected 1, got %h",
                                     readBusy));
        assert (!pixelValid)
        else reportFailure($sformatf("Fail pixelValid after readStart: expected 0, got %h",
                                     pixelValid));
        @(negedge clk);
        expIndex = '0;
        for (int i = 0; i < NUM_PIXELS; i++)
        begin
            assert (pixelValid)
            else reportFailure($sformatf("Fail pixelValid at pixel %h: expected 1, got %h",
                                         expIndex, pixelValid));
            assert (readBusy)
            else reportFailure($sformatf("Fail readBusy at pixel %h: expected 1, got %h",
                                         expIndex, readBusy));
            assert (pixelIndex == expIndex)
            else reportFailure($sformatf("Fail pixelIndex: expected %h, got %h",
                                         expIndex, pixelIndex));
            assert (pixelData == modelColor[expIndex])
            else reportFailure($sformatf("Fail pixelData at index %h: expected %h, got %h",
                                         expIndex, modelColor[expIndex], pixelData));
            expIndex = expIndex + 1'b1;
            @(negedge clk);
        end
        assert (!pixelValid)
        else reportFailure($sformatf("Fail pixelValid after the scan: expected 0, got %h",
                                     pixelValid));
        assert (!readBusy)
        else reportFailure($sformatf("Fail readBusy after the scan: expected 0, got %h",
                                     readBusy));
    endtask

    initial
    begin
        void'($urandom(SEED));
        reset            <= 1'b1;
        fragValid        <= 1'b0;
        fragAddr         <= '0;
        fragDepth        <= '0;
        fragColor        <= '0;
        colorMask        <= '0;
        depthFunc        <= depthNever;
        depthWriteEnable <= 1'b0;
        clearStart       <= 1'b0;
        clearColor       <= '0;
        clearDepth       <= '0;
        readStart        <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!clearBusy)
        else reportFailure($sformatf("Fail clearBusy after reset: expected 0, got %h",
                                     clearBusy));
        assert (!readBusy)
        else reportFailure($sformatf("Fail readBusy after reset: expected 0, got %h",
                                     readBusy));
        assert (!pixelValid)
        else reportFailure($sformatf("Fail pixelValid after reset: expected 0, got %h",
                                     pixelValid));

        // uniform tile straight after the first clear
        clearTile(16'h8421, 16'h8000);
        readTile();

        // fully random traffic over the whole tile
        for (int n = 0; n < RANDOM_FRAGS; n++)
        begin
            rndA = $urandom();
            rndB = $urandom();
            sendFragment(rndA[TILE_ADDR_BITS-1:0], rndA[31:16], rndB[15:0], rndA[11:8],
                         depthFuncT'(rndA[14:12]), rndA[15]);
        end
        drainPipeline();
        readTile();

        // back to back hits on four addresses with depths close to the cleared value
        clearTile(16'h0000, 16'h0104);
        for (int n = 0; n < HOT_FRAGS; n++)
        begin
            rndA = $urandom();
            rndB = $urandom();
            sendFragment(HOT_ADDR[rndA[1:0]], 16'h0100 + {13'd0, rndA[4:2]}, rndB[15:0],
                         rndA[11:8], depthFuncT'(rndA[14:12]), rndA[15] | rndA[16]);
        end
        drainPipeline();
        readTile();

        clearTile(16'h0F0F, 16'h4000);
        for (int n = 0; n < SPECIAL_FRAGS; n++)
        begin
            rndA = $urandom();
            rndB = $urandom();
            sendFragment(rndA[TILE_ADDR_BITS-1:0], rndA[31:16], rndB[15:0], 4'hF,
                         depthNever, 1'b1);
            sendFragment(rndB[TILE_ADDR_BITS-1:0], rndB[31:16], rndA[15:0], 4'h0,
                         depthAlways, 1'b0); // zero mask keeps the colour
        end
        // the colour of the low addresses changes here while their depth stays at the clear value
        for (int a = 0; a < SPECIAL_FRAGS; a++)
        begin
            rndA = $urandom();
            sendFragment(a[TILE_ADDR_BITS-1:0], rndA[31:16], {8'hC3, a[7:0]}, 4'hF,
                         depthAlways, 1'b0);
        end
        for (int a = 0; a < SPECIAL_FRAGS; a++)
        begin
            rndA = $urandom();
            sendFragment(a[TILE_ADDR_BITS-1:0], 16'h4000, {8'h3C, a[7:0]}, 4'hF,
                         depthEqual, rndA[0]);
        end
        drainPipeline();
        readTile();

        // a second clear after all that traffic
        clearTile(16'hFACE, 16'hFFFF);
        readTile();

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial
    begin
        #WATCHDOG_NS;
        reportFailure("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

//--- rtl/tileBuffer.sv
`timescale 1ns/10ps
`default_nettype none

// per-tile pixel store with colour and depth buffers, depth test,
// clear sweep and colour readback
module tileBuffer #(
    parameter int TILE_ADDR_BITS = tilePkg::TILE_ADDR_BITS
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fragValid,
    input  logic [TILE_ADDR_BITS-1:0] fragAddr,
    input  tilePkg::depthT            fragDepth,
    input  tilePkg::colorT            fragColor,
    input  logic [tilePkg::COLOR_BITS/tilePkg::CHANNEL_BITS-1:0] colorMask,
    input  tilePkg::depthFuncT        depthFunc,
    input  logic                      depthWriteEnable,
    input  logic                      clearStart,
    input  tilePkg::colorT            clearColor,
    input  tilePkg::depthT            clearDepth,
    output logic                      clearBusy,
    input  logic                      readStart,
    output logic                      readBusy,
    output logic                      pixelValid,
    output logic [TILE_ADDR_BITS-1:0] pixelIndex,
    output tilePkg::colorT            pixelData
);

    import tilePkg::*;

    localparam int COLOR_LANES = COLOR_BITS / CHANNEL_BITS;

    logic [TILE_ADDR_BITS-1:0] depthReadAddr;
    depthT                     depthReadData;
    logic [TILE_ADDR_BITS-1:0] colorReadAddr;
    colorT                     colorReadData;

    // fragment writes from the pipeline, before the clear mux
    ramWriteIf #(.ADDR_BITS(TILE_ADDR_BITS), .DATA_BITS(COLOR_BITS), .MASK_BITS(COLOR_LANES))
        colorFragWrite ();
    ramWriteIf #(.ADDR_BITS(TILE_ADDR_BITS), .DATA_BITS(DEPTH_BITS), .MASK_BITS(1))
        depthFragWrite ();

    // what the RAMs actually see
    ramWriteIf #(.ADDR_BITS(TILE_ADDR_BITS), .DATA_BITS(COLOR_BITS), .MASK_BITS(COLOR_LANES))
        colorWrite ();
    ramWriteIf #(.ADDR_BITS(TILE_ADDR_BITS), .DATA_BITS(DEPTH_BITS), .MASK_BITS(1))
        depthWrite ();

    depthTest #(.ADDR_BITS(TILE_ADDR_BITS)) depthTest_i (
        .clk              (clk),
        .reset            (reset),
        .fragValid        (fragValid),
        .fragAddr         (fragAddr),
        .fragDepth        (fragDepth),
        .fragColor        (fragColor),
        .colorMask        (colorMask),
        .depthFunc        (depthFunc),
        .depthWriteEnable (depthWriteEnable),
        .depthReadAddr    (depthReadAddr),
        .depthReadData    (depthReadData),
        .colorWrite       (colorFragWrite),
        .depthWrite       (depthFragWrite)
    );

    tileClear #(.ADDR_BITS(TILE_ADDR_BITS)) tileClear_i (
        .clk            (clk),
        .reset          (reset),
        .clearStart     (clearStart),
        .clearColor     (clearColor),
        .clearDepth     (clearDepth),
        .clearBusy      (clearBusy),
        .colorFragWrite (colorFragWrite),
        .depthFragWrite (depthFragWrite),
        .colorWrite     (colorWrite),
        .depthWrite     (depthWrite)
    );

    tileReadback #(.ADDR_BITS(TILE_ADDR_BITS)) tileReadback_i (
        .clk           (clk),
        .reset         (reset),
        .readStart     (readStart),
        .readBusy      (readBusy),
        .colorReadAddr (colorReadAddr),
        .colorReadData (colorReadData),
        .pixelValid    (pixelValid),
        .pixelIndex    (pixelIndex),
        .pixelData     (pixelData)
    );

    // colour lanes are single channels so the mask works per channel
    dualPortRam #(
        .ADDR_BITS   (TILE_ADDR_BITS),
        .DATA_BITS   (COLOR_BITS),
        .STROBE_BITS (CHANNEL_BITS)
    ) colorRam (
        .clk      (clk),
        .reset    (reset),
        .wr       (colorWrite),
        .readAddr (colorReadAddr),
        .readData (colorReadData)
    );

    dualPortRam #(
        .ADDR_BITS   (TILE_ADDR_BITS),
        .DATA_BITS   (DEPTH_BITS),
        .STROBE_BITS (DEPTH_BITS)
    ) depthRam (
        .clk      (clk),
        .reset    (reset),
        .wr       (depthWrite),
        .readAddr (depthReadAddr),
        .readData (depthReadData)
    );

endmodule

`default_nettype wire

//--- rtl/tileReadback.sv
`timescale 1ns/10ps
`default_nettype none

// readback streamer, scans the colour buffer in address order
// and sends out one pixel per cycle
module tileReadback #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 readStart,
    output logic                 readBusy,
    output logic [ADDR_BITS-1:0] colorReadAddr,
    input  tilePkg::colorT       colorReadData,
    output logic                 pixelValid,
    output logic [ADDR_BITS-1:0] pixelIndex,
    output tilePkg::colorT       pixelData
);

    logic                 scanActive; // high while addresses are being issued
    logic [ADDR_BITS-1:0] scanAddr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            scanActive <= 1'b0;
            scanAddr   <= '0;
            pixelValid <= 1'b0;
        end
        else
        begin
            if (!scanActive && readStart)
            begin
                scanActive <= 1'b1;
                scanAddr   <= '0;
            end
            else if (scanActive)
            begin
                scanAddr <= scanAddr + 1'b1;
                if (scanAddr == '1)
                begin
                    scanActive <= 1'b0; // the final address is in the RAM now
                end
            end
            pixelValid <= scanActive; // the RAM output trails its address by one cycle
        end
    end

    always_ff @(posedge clk)
    begin
        pixelIndex <= scanAddr;
    end

    assign colorReadAddr = scanAddr;
    assign pixelData     = colorReadData; // already registered inside the RAM

    // stays up until the last pixel has left
    assign readBusy = scanActive || pixelValid;

endmodule

`default_nettype wire

//--- rtl/tileClear.sv
`timescale 1ns/10ps
`default_nettype none

// clear sequencer, sweeps both buffers with the clear values one address per
// cycle and otherwise hands the fragment writes on to the RAMs
module tileClear #(
    parameter int ADDR_BITS = 8
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           clearStart,
    input  tilePkg::colorT clearColor,
    input  tilePkg::depthT clearDepth,
    output logic           clearBusy,
    ramWriteIf.sink        colorFragWrite,
    ramWriteIf.sink        depthFragWrite,
    ramWriteIf.source      colorWrite,
    ramWriteIf.source      depthWrite
);

    import tilePkg::*;

    typedef enum logic {
        stateIdle,
        stateClearing
    } clearStateT;

    clearStateT           state;
    logic [ADDR_BITS-1:0] clearAddr;
    colorT                clearColorReg; // held for the whole sweep
    depthT                clearDepthReg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= stateIdle;
            clearAddr <= '0;
        end
        else
        begin
            case (state)
                stateIdle:
                begin
                    if (clearStart)
                    begin
                        state     <= stateClearing;
                        clearAddr <= '0;
                    end
                end
                default:
                begin
                    clearAddr <= clearAddr + 1'b1;
                    if (clearAddr == '1)
                    begin
                        state <= stateIdle; // last address goes out on this edge
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == stateIdle) && clearStart)
        begin
            clearColorReg <= clearColor;
            clearDepthReg <= clearDepth;
        end
    end

    assign clearBusy = (state == stateClearing);

    // fragment writes arriving during the sweep are dropped
    assign colorWrite.write = clearBusy ? 1'b1 : colorFragWrite.write;
    assign colorWrite.addr  = clearBusy ? clearAddr : colorFragWrite.addr;
    assign colorWrite.data  = clearBusy ? clearColorReg : colorFragWrite.data;
    assign colorWrite.mask  = clearBusy ? '1 : colorFragWrite.mask;

    assign depthWrite.write = clearBusy ? 1'b1 : depthFragWrite.write;
    assign depthWrite.addr  = clearBusy ? clearAddr : depthFragWrite.addr;
    assign depthWrite.data  = clearBusy ? clearDepthReg : depthFragWrite.data;
    assign depthWrite.mask  = clearBusy ? '1 : depthFragWrite.mask;

endmodule

`default_nettype wire

//--- rtl/depthTest.sv
`timescale 1ns/10ps
`default_nettype none

// two-stage depth test pipeline
// stage 0 samples the fragment while the depth RAM reads the stored value,
// stage 1 compares and registers the colour and depth writes
module depthTest #(
    parameter int ADDR_BITS = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fragValid,
    input  logic [ADDR_BITS-1:0]  fragAddr,
    input  tilePkg::depthT        fragDepth,
    input  tilePkg::colorT        fragColor,
    input  logic [tilePkg::COLOR_BITS/tilePkg::CHANNEL_BITS-1:0] colorMask,
    input  tilePkg::depthFuncT    depthFunc,
    input  logic                  depthWriteEnable,
    output logic [ADDR_BITS-1:0]  depthReadAddr,
    input  tilePkg::depthT        depthReadData,
    ramWriteIf.source             colorWrite,
    ramWriteIf.source             depthWrite
);

    import tilePkg::*;

    localparam int COLOR_LANES = COLOR_BITS / CHANNEL_BITS;

    // stage 1 copy of the fragment
    logic                   s1Valid;
    logic [ADDR_BITS-1:0]   s1Addr;
    depthT                  s1Depth;
    colorT                  s1Color;
    logic [COLOR_LANES-1:0] s1ColorMask;
    depthFuncT              s1Func;
    logic                   s1DepthWriteEnable;

    // entry 0 is the depth write now on the RAM port, entry 1 the one committed
    // on the last edge, which the RAM read of this fragment did not see yet
    logic [1:0]           fwdValid;
    logic [ADDR_BITS-1:0] fwdAddr [2];
    depthT                fwdDepth [2];

    depthT storedDepth; // stored depth after forwarding
    logic  fragPass;

    function automatic logic compareDepth(
        input depthFuncT func,
        input depthT     incoming,
        input depthT     stored
    );
        logic result;
        case (func)
            depthNever:        result = 1'b0;
            depthLess:         result = incoming < stored;
            depthLessEqual:    result = incoming <= stored;
            depthEqual:        result = incoming == stored;
            depthGreater:      result = incoming > stored;
            depthGreaterEqual: result = incoming >= stored;
            depthNotEqual:     result = incoming != stored;
            default:           result = 1'b1; // depthAlways
        endcase
        return result;
    endfunction

    // the read is issued straight from the input, so the stored depth
    // sits in the RAM output register on the same edge that fills stage 1
    assign depthReadAddr = fragAddr;

    always_comb
    begin
        storedDepth = depthReadData;
        if (fwdValid[1] && (fwdAddr[1] == s1Addr))
        begin
            storedDepth = fwdDepth[1];
        end
        if (fwdValid[0] && (fwdAddr[0] == s1Addr))
        begin
            storedDepth = fwdDepth[0]; // the newest write wins over the older entry
        end
    end

    assign fragPass = s1Valid && compareDepth(s1Func, s1Depth, storedDepth);

    // control state of both stages and the forward entries
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1Valid          <= 1'b0;
            colorWrite.write <= 1'b0;
            fwdValid         <= 2'b00;
        end
        else
        begin
            s1Valid          <= fragValid;
            colorWrite.write <= fragPass;
            fwdValid         <= {fwdValid[0], fragPass && s1DepthWriteEnable};
        end
    end

    // payload registers, only qualified by the valid bits above
    always_ff @(posedge clk)
    begin
        s1Addr             <= fragAddr;
        s1Depth            <= fragDepth;
        s1Color            <= fragColor;
        s1ColorMask        <= colorMask;
        s1Func             <= depthFunc;
        s1DepthWriteEnable <= depthWriteEnable;

        colorWrite.addr <= s1Addr;
        colorWrite.data <= s1Color;
        colorWrite.mask <= s1ColorMask; // a zero mask leaves the pixel as it was

        fwdAddr[0]  <= s1Addr;
        fwdDepth[0] <= s1Depth;
        fwdAddr[1]  <= fwdAddr[0]; // shifts along whether or not entry 0 was valid
        fwdDepth[1] <= fwdDepth[0];
    end

    // depth writes always cover the whole word
    assign depthWrite.write = fwdValid[0];
    assign depthWrite.addr  = fwdAddr[0];
    assign depthWrite.data  = fwdDepth[0];
    assign depthWrite.mask  = '1;

endmodule

`default_nettype wire

//--- rtl/dualPortRam.sv
`timescale 1ns/10ps
`default_nettype none

// behavioural simple dual-port RAM with one write port and one read port
module dualPortRam #(
    parameter int ADDR_BITS   = 8,
    parameter int DATA_BITS   = 16,
    parameter int STROBE_BITS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    ramWriteIf.sink              wr,
    input  logic [ADDR_BITS-1:0] readAddr,
    output logic [DATA_BITS-1:0] readData
);

    localparam int LANES = DATA_BITS / STROBE_BITS; // one mask bit per lane
    localparam int DEPTH = 1 << ADDR_BITS;

    logic [DATA_BITS-1:0] mem [DEPTH];

    // each lane is written on its own, so a partial mask keeps the other lanes
    always_ff @(posedge clk)
    begin
        for (int lane = 0; lane < LANES; lane++)
        begin
            if (wr.write && wr.mask[lane])
            begin
                mem[wr.addr][lane*STROBE_BITS +: STROBE_BITS] <=
                    wr.data[lane*STROBE_BITS +: STROBE_BITS];
            end
        end
    end

    // registered read, a write to the same address on the same edge is not seen yet
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            readData <= '0; // output register only, the array itself keeps its contents
        end
        else
        begin
            readData <= mem[readAddr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/ramWriteIf.sv
`timescale 1ns/10ps
`default_nettype none

// one write port of a simple dual-port RAM
// mask holds one bit per write lane of the data word
interface ramWriteIf #(
    parameter int ADDR_BITS = 8,
    parameter int DATA_BITS = 16,
    parameter int MASK_BITS = 4
);

    logic                 write; // single-cycle write strobe
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
    logic [MASK_BITS-1:0] mask; // lanes whose bit is clear keep their old contents

    // the side that produces write requests
    modport source (
        output write,
        output addr,
        output data,
        output mask
    );

    // the RAM side, or a block that forwards the requests on
    modport sink (
        input write,
        input addr,
        input data,
        input mask
    );

endinterface

`default_nettype wire

//--- rtl/tilePkg.sv
`default_nettype none

package tilePkg;

    // a tile is 16 by 16 pixels, addressed linearly in raster order
    localparam int TILE_ADDR_BITS = 8;

    localparam int COLOR_BITS = 16; // RGBA4444, red in the top nibble
    localparam int DEPTH_BITS = 16; // unsigned depth, smaller is nearer
    localparam int CHANNEL_BITS = 4; // one colour channel, also the colour RAM lane width

    typedef logic [COLOR_BITS-1:0] colorT;
    typedef logic [DEPTH_BITS-1:0] depthT;

    // each function compares the incoming fragment depth against the stored depth
    typedef enum logic [2:0] {
        depthNever        = 3'd0, // the fragment is always rejected
        depthLess         = 3'd1,
        depthLessEqual    = 3'd2,
        depthEqual        = 3'd3,
        depthGreater      = 3'd4,
        depthGreaterEqual = 3'd5,
        depthNotEqual     = 3'd6,
        depthAlways       = 3'd7  // the fragment passes whatever is stored
    } depthFuncT;

endpackage

`default_nettype wire
